/* all.f */
design/pixels_pkg.sv
design/pixel_repacker.sv
design/shift_sequencer.sv
design/pixels_dw_ctrl.sv
design/pixels_dw_top.sv
bench/pixels_dw_sva.sv
bench/tb_pixels_dw.sv

/* Bender.yml */
package:
  name: pixels_dw

sources:
  - files:
      - design/pixels_pkg.sv
      - design/pixel_repacker.sv
      - design/shift_sequencer.sv
      - design/pixels_dw_ctrl.sv
      - design/pixels_dw_top.sv
  - target: test
    files:
      - bench/pixels_dw_sva.sv
      - bench/tb_pixels_dw.sv

/* bench/tb_pixels_dw.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pixels_dw;

  import pixels_pkg::*;

  localparam int WORD_WIDTH = 8;
  localparam int S_WORDS    = 4;
  localparam int M_WORDS    = 8;
  localparam int S_BITS     = S_WORDS * WORD_WIDTH;
  localparam int MAX_CYCLES = 4000;  // Several times the longest image set.

  typedef struct packed {
    logic                          ones;
    logic [TUSER_WIDTH-1:0]        user;
    logic [BITS_SHIFT-1:0]         shift;
    logic [M_WORDS*WORD_WIDTH-1:0] data;
  } beat_t;

  logic                               aclk;
  logic                               i_arst_n;
  logic                               i_s_valid;
  logic                               i_s_last;
  logic [S_WORDS-1:0][WORD_WIDTH-1:0] i_s_data;
  logic [S_WORDS-1:0]                 i_s_keep;
  logic                               i_m_ready;
  logic                               o_s_ready;
  logic                               o_m_valid;
  logic [M_WORDS-1:0][WORD_WIDTH-1:0] o_m_data;
  logic [TUSER_WIDTH-1:0]             o_m_user;
  logic [BITS_SHIFT-1:0]              o_m_shift;
  logic                               o_m_ones;

  logic [S_BITS-1:0]  img_data [$];
  logic [S_WORDS-1:0] img_keep [$];
  beat_t              exp_q [$];
  beat_t              exp_beat;
  int                 ready_pct;
  int                 cycles;
  int                 mismatches;
  int                 other_errors;

  pixels_dw_top #(
    .WORD_WIDTH (WORD_WIDTH),
    .S_WORDS    (S_WORDS),
    .M_WORDS    (M_WORDS)
  ) u_pixels_dw_top (.*);

  initial begin : clock_gen
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  function automatic logic [CFG_WIDTH-1:0] make_cfg(input int words, input int kh2,
                                                    input int sh_1, input int flags);
    return CFG_WIDTH'((words << CFG_WORDS_LSB) | (sh_1 << CFG_SH_1_LSB)
                      | (kh2 << CFG_KH2_LSB) | flags);
  endfunction

  // ========================================
  // Reference model
  // ========================================
  function automatic void expected_beats(input logic [CFG_WIDTH-1:0] cfg);
    logic [WORD_WIDTH-1:0]  kept [$];
    logic [TUSER_WIDTH-1:0] user;
    beat_t                  b;
    int                     words;
    int                     k;
    int                     s;
    int                     ceil_ks;
    int                     floor_ks;
    words    = int'(cfg[CFG_WORDS_LSB +: BITS_WORDS]);
    k        = 2 * int'(cfg[CFG_KH2_LSB +: BITS_KH2]) + 1;
    s        = int'(cfg[CFG_SH_1_LSB +: BITS_SH]) + 1;
    ceil_ks  = (k + s - 1) / s - 1;
    floor_ks = (k / s > 0) ? k / s - 1 : 0;  // Stride wider than kernel gives zero.
    user[I_IS_NOT_MAX] = cfg[CFG_IS_NOT_MAX];
    user[I_IS_MAX]     = cfg[CFG_IS_MAX];
    user[I_IS_LRELU]   = cfg[CFG_IS_LRELU];
    b        = '0;
    b.ones   = 1'b1;
    b.user   = user;
    b.data[WORD_WIDTH-1:0] = WORD_WIDTH'(1);
    exp_q.push_back(b);
    foreach (img_data[n]) begin
      for (int i = 0; i < S_WORDS; i++) begin
        if (img_keep[n][i]) kept.push_back(img_data[n][i*WORD_WIDTH +: WORD_WIDTH]);
      end
    end
    for (int g = 0; g * words < kept.size(); g++) begin
      b       = '0;
      b.user  = user;
      b.shift = BITS_SHIFT'((g % s == s - 1) ? floor_ks : ceil_ks);
      for (int w = 0; w < words; w++) begin
        if (g * words + w < kept.size()) begin
          b.data[w*WORD_WIDTH +: WORD_WIDTH] = kept[g*words+w];
        end
      end
      exp_q.push_back(b);
    end
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else begin
      mismatches++;
      $display("MISMATCH %s: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic send_beat(input logic [S_BITS-1:0] data, input logic [S_WORDS-1:0] keep,
                           input logic last);
    logic taken;
    repeat ($urandom_range(0, 2)) begin
      @(posedge aclk);
      #2;
    end
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_keep  = keep;
    i_s_last  = last;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = o_s_ready;  // Settled until the next edge.
      @(posedge aclk);
      #2;
    end
    i_s_valid = 1'b0;
  endtask

  task automatic run_image(input logic [CFG_WIDTH-1:0] cfg, input int n_beats, input int pct);
    logic [S_WORDS-1:0] keep;
    img_data.delete();
    img_keep.delete();
    for (int n = 0; n < n_beats; n++) begin
      keep = S_WORDS'($urandom_range(0, 2 ** S_WORDS - 1));
      // First and last beats always carry a word.
      if ((n == 0 || n == n_beats - 1) && keep == '0) keep = S_WORDS'(1);
      img_data.push_back(S_BITS'($urandom()));
      img_keep.push_back(keep);
    end
    expected_beats(cfg);
    ready_pct = pct;
    send_beat(S_BITS'(cfg), '1, 1'b0);
    for (int n = 0; n < n_beats; n++) begin
      send_beat(img_data[n], img_keep[n], n == n_beats - 1);
    end
  endtask

  always begin : drive_ready
    @(posedge aclk);
    #2;
    i_m_ready = ($urandom_range(0, 99) < ready_pct);
  end

  always begin : compare_outputs
    @(negedge aclk);
    if (i_arst_n && o_m_valid && i_m_ready) begin
      assert (exp_q.size() > 0) else begin
        other_errors++;
        $display("ERROR: output beat transferred with no expected beat pending");
      end
      if (exp_q.size() > 0) begin
        exp_beat = exp_q.pop_front();
        check_value("o_m_data", 64'(o_m_data), 64'(exp_beat.data));
        check_value("o_m_user", 64'(o_m_user), 64'(exp_beat.user));
        check_value("o_m_shift", 64'(o_m_shift), 64'(exp_beat.shift));
        check_value("o_m_ones", 64'(o_m_ones), 64'(exp_beat.ones));
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge aclk);
      cycles++;
    end
    other_errors++;
    $display("ERROR: timeout, output stream not finished after %0d cycles", MAX_CYCLES);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    $display("FAIL: see errors above");
    $finish;
  end

  // ========================================
  // Main sequence
  // ========================================
  initial begin : main_sequence
    void'($urandom(32'hdac7d39f));
    i_arst_n     = 1'b0;
    i_s_valid    = 1'b0;
    i_s_last     = 1'b0;
    i_s_data     = '0;
    i_s_keep     = '0;
    i_m_ready    = 1'b0;
    ready_pct    = 100;
    mismatches   = 0;
    other_errors = 0;
    repeat (16) begin
      @(negedge aclk);
      check_value("o_m_valid", 64'(o_m_valid), 64'h0);
      check_value("o_s_ready", 64'(o_s_ready), 64'h1);
    end
    @(posedge aclk);
    #2;
    i_arst_n = 1'b1;
    @(negedge aclk);
    check_value("o_m_valid", 64'(o_m_valid), 64'h0);
    check_value("o_s_ready", 64'(o_s_ready), 64'h1);
    @(posedge aclk);
    #2;
    run_image(make_cfg(8, 1, 0, 3'b001), 6, 100);
    run_image(make_cfg(3, 3, 1, 3'b110), 8, 70);
    run_image(make_cfg(5, 2, 2, 3'b101), 7, 50);
    run_image(make_cfg(1, 3, 3, 3'b010), 4, 60);
    run_image(make_cfg(4, 0, 1, 3'b100), 5, 20);  // Heavy stall around the last beat.
    run_image(make_cfg(7, 2, 0, 3'b011), 9, 80);
    while (exp_q.size() != 0) @(posedge aclk);
    repeat (8) @(posedge aclk);
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/pixels_dw_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module pixels_dw_sva #(
  parameter int WORD_WIDTH = 8,
  parameter int M_WORDS    = 8
) (
  input wire                                aclk,
  input wire                                i_arst_n,
  input wire                                i_m_ready,
  input wire                                o_m_valid,
  input wire [M_WORDS-1:0][WORD_WIDTH-1:0]  o_m_data,
  input wire [pixels_pkg::TUSER_WIDTH-1:0]  o_m_user,
  input wire [pixels_pkg::BITS_SHIFT-1:0]   o_m_shift,
  input wire                                o_m_ones
);

  a_reset_quiet: assert property (@(posedge aclk) !i_arst_n |-> (!o_m_valid && !o_m_ones))
    else $error("o_m_valid or o_m_ones high while reset is applied");

  // A stalled output beat holds until it transfers.
  a_valid_hold: assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && !i_m_ready) |=> o_m_valid)
    else $error("o_m_valid dropped before i_m_ready");

  a_beat_stable: assert property (@(posedge aclk) disable iff (!i_arst_n)
    (o_m_valid && !i_m_ready) |=> ($stable(o_m_data) && $stable(o_m_user)
                                   && $stable(o_m_shift) && $stable(o_m_ones)))
    else $error("output beat changed while stalled");

  a_ones_valid: assert property (@(posedge aclk) o_m_ones |-> o_m_valid)
    else $error("o_m_ones high without o_m_valid");

endmodule

bind pixels_dw_top pixels_dw_sva #(.WORD_WIDTH(WORD_WIDTH), .M_WORDS(M_WORDS)) u_sva (
  .aclk      (aclk),
  .i_arst_n  (i_arst_n),
  .i_m_ready (i_m_ready),
  .o_m_valid (o_m_valid),
  .o_m_data  (o_m_data),
  .o_m_user  (o_m_user),
  .o_m_shift (o_m_shift),
  .o_m_ones  (o_m_ones)
);

`default_nettype wire

/* design/pixels_dw_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pixels_dw_top #(
  parameter int WORD_WIDTH = 8,
  parameter int S_WORDS    = 4,
  parameter int M_WORDS    = 8   // At most 15, no less than S_WORDS.
) (
  input  wire                                  aclk,
  input  wire                                  i_arst_n,
  input  wire                                  i_s_valid,
  input  wire                                  i_s_last,
  input  wire  [S_WORDS-1:0][WORD_WIDTH-1:0]   i_s_data,
  input  wire  [S_WORDS-1:0]                   i_s_keep,
  input  wire                                  i_m_ready,
  output logic                                 o_s_ready,
  output logic                                 o_m_valid,
  output logic [M_WORDS-1:0][WORD_WIDTH-1:0]   o_m_data,
  output logic [pixels_pkg::TUSER_WIDTH-1:0]   o_m_user,
  output logic [pixels_pkg::BITS_SHIFT-1:0]    o_m_shift,
  output logic                                 o_m_ones
);

  import pixels_pkg::*;

  logic                                rp_s_valid;
  logic                                rp_s_ready;
  logic                                rp_m_valid;
  logic                                rp_m_ready;
  logic [M_WORDS-1:0][WORD_WIDTH-1:0]  rp_m_data;
  logic                                rp_m_last;
  logic [BITS_WORDS-1:0]               cfg_words;
  logic [BITS_KH2-1:0]                 cfg_kh2;
  logic [BITS_SH-1:0]                  cfg_sh_1;
  logic                                data_beat;
  logic                                image_done;
  logic [BITS_SHIFT-1:0]               shift;

  pixels_dw_ctrl #(
    .WORD_WIDTH (WORD_WIDTH),
    .S_WORDS    (S_WORDS),
    .M_WORDS    (M_WORDS)
  ) u_ctrl (
    .aclk         (aclk),
    .i_arst_n     (i_arst_n),
    .i_s_valid    (i_s_valid),
    .i_s_last     (i_s_last),
    .i_s_data     (i_s_data),
    .i_m_ready    (i_m_ready),
    .i_rp_s_ready (rp_s_ready),
    .i_rp_m_valid (rp_m_valid),
    .i_rp_m_data  (rp_m_data),
    .i_rp_m_last  (rp_m_last),
    .i_shift      (shift),
    .o_s_ready    (o_s_ready),
    .o_m_valid    (o_m_valid),
    .o_m_data     (o_m_data),
    .o_m_user     (o_m_user),
    .o_m_shift    (o_m_shift),
    .o_m_ones     (o_m_ones),
    .o_rp_s_valid (rp_s_valid),
    .o_rp_m_ready (rp_m_ready),
    .o_cfg_words  (cfg_words),
    .o_cfg_kh2    (cfg_kh2),
    .o_cfg_sh_1   (cfg_sh_1),
    .o_data_beat  (data_beat),
    .o_image_done (image_done)
  );

  pixel_repacker #(
    .WORD_WIDTH (WORD_WIDTH),
    .S_WORDS    (S_WORDS),
    .M_WORDS    (M_WORDS)
  ) u_repacker (
    .aclk      (aclk),
    .i_arst_n  (i_arst_n),
    .i_words   (cfg_words),
    .i_s_valid (rp_s_valid),
    .i_s_last  (i_s_last),
    .i_s_data  (i_s_data),
    .i_s_keep  (i_s_keep),
    .i_m_ready (rp_m_ready),
    .o_s_ready (rp_s_ready),
    .o_m_valid (rp_m_valid),
    .o_m_data  (rp_m_data),
    .o_m_last  (rp_m_last)
  );

  shift_sequencer u_shift (
    .aclk     (aclk),
    .i_arst_n (i_arst_n),
    .i_kh2    (cfg_kh2),
    .i_sh_1   (cfg_sh_1),
    .i_beat   (data_beat),
    .i_clear  (image_done),
    .o_shift  (shift)
  );

endmodule

`default_nettype wire

/* design/pixels_dw_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pixels_dw_ctrl #(
  parameter int WORD_WIDTH = 8,
  parameter int S_WORDS    = 4,
  parameter int M_WORDS    = 8
) (
  input  wire                                  aclk,
  input  wire                                  i_arst_n,
  input  wire                                  i_s_valid,
  input  wire                                  i_s_last,
  input  wire  [S_WORDS-1:0][WORD_WIDTH-1:0]   i_s_data,
  input  wire                                  i_m_ready,
  input  wire                                  i_rp_s_ready,
  input  wire                                  i_rp_m_valid,
  input  wire  [M_WORDS-1:0][WORD_WIDTH-1:0]   i_rp_m_data,
  input  wire                                  i_rp_m_last,
  input  wire  [pixels_pkg::BITS_SHIFT-1:0]    i_shift,
  output logic                                 o_s_ready,
  output logic                                 o_m_valid,
  output logic [M_WORDS-1:0][WORD_WIDTH-1:0]   o_m_data,
  output logic [pixels_pkg::TUSER_WIDTH-1:0]   o_m_user,
  output logic [pixels_pkg::BITS_SHIFT-1:0]    o_m_shift,
  output logic                                 o_m_ones,
  output logic                                 o_rp_s_valid,
  output logic                                 o_rp_m_ready,
  output logic [pixels_pkg::BITS_WORDS-1:0]    o_cfg_words,
  output logic [pixels_pkg::BITS_KH2-1:0]      o_cfg_kh2,
  output logic [pixels_pkg::BITS_SH-1:0]       o_cfg_sh_1,
  output logic                                 o_data_beat,
  output logic                                 o_image_done
);

  import pixels_pkg::*;

  dw_state_e                     state;
  dw_state_e                     state_next;
  logic [CFG_WIDTH-1:0]          cfg;
  logic                          cfg_en;
  logic [S_WORDS*WORD_WIDTH-1:0] s_flat;
  logic                          s_last_beat;
  logic                          rp_m_beat;
  logic                          rp_last_beat;

  assign s_flat       = i_s_data;
  assign s_last_beat  = i_s_valid && o_s_ready && i_s_last;
  assign rp_m_beat    = o_rp_m_ready && i_rp_m_valid;
  assign rp_last_beat = rp_m_beat && i_rp_m_last;

  // ========================================
  // Configuration register
  // ========================================
  assign cfg_en = (state == ST_SET) && i_s_valid;

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cfg <= '0;
    end else if (cfg_en) begin
      cfg <= s_flat[CFG_WIDTH-1:0];
    end
  end

  assign o_cfg_words = cfg[CFG_WORDS_LSB +: BITS_WORDS];
  assign o_cfg_kh2   = cfg[CFG_KH2_LSB +: BITS_KH2];
  assign o_cfg_sh_1  = cfg[CFG_SH_1_LSB +: BITS_SH];

  assign o_m_user[I_IS_NOT_MAX] = cfg[CFG_IS_NOT_MAX];
  assign o_m_user[I_IS_MAX]     = cfg[CFG_IS_MAX];
  assign o_m_user[I_IS_LRELU]   = cfg[CFG_IS_LRELU];

  assign o_data_beat  = rp_m_beat;     // Only nonzero in PASS and BLOCK.
  assign o_image_done = rp_last_beat;

  // ========================================
  // State machine
  // ========================================
  always_comb begin
    state_next = state;
    case (state)
      ST_SET:   if (i_s_valid) state_next = ST_ONES;
      ST_ONES:  if (i_m_ready) state_next = ST_PASS;
      // A last beat taken during ONES still ends the image here.
      ST_PASS: begin
        if (rp_last_beat) begin
          state_next = ST_SET;
        end else if (s_last_beat) begin
          state_next = ST_BLOCK;
        end
      end
      ST_BLOCK: if (rp_last_beat) state_next = ST_SET;
      default:  state_next = ST_SET;
    endcase
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ST_SET;
    end else begin
      state <= state_next;
    end
  end

  // Handshake and output mux per state.
  always_comb begin
    o_s_ready    = 1'b0;
    o_rp_s_valid = 1'b0;
    o_rp_m_ready = 1'b0;
    o_m_valid    = 1'b0;
    o_m_ones     = 1'b0;
    o_m_data     = i_rp_m_data;
    o_m_shift    = i_shift;
    case (state)
      ST_SET: begin
        o_s_ready = 1'b1;
      end
      ST_ONES: begin
        o_s_ready    = i_rp_s_ready;  // Pixels may start filling already.
        o_rp_s_valid = i_s_valid;
        o_m_valid    = 1'b1;
        o_m_ones     = 1'b1;
        o_m_data     = '0;
        o_m_data[0]  = WORD_WIDTH'(1);
        o_m_shift    = '0;
      end
      ST_PASS: begin
        o_s_ready    = i_rp_s_ready;
        o_rp_s_valid = i_s_valid;
        o_rp_m_ready = i_m_ready;
        o_m_valid    = i_rp_m_valid;
      end
      ST_BLOCK: begin
        o_rp_m_ready = i_m_ready;
        o_m_valid    = i_rp_m_valid;
      end
      default: begin
        o_s_ready = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/shift_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_sequencer (
  input  wire                                 aclk,
  input  wire                                 i_arst_n,
  input  wire  [pixels_pkg::BITS_KH2-1:0]     i_kh2,
  input  wire  [pixels_pkg::BITS_SH-1:0]      i_sh_1,
  input  wire                                 i_beat,
  input  wire                                 i_clear,
  output logic [pixels_pkg::BITS_SHIFT-1:0]   o_shift
);

  import pixels_pkg::*;

  localparam int N_KH2 = 2 ** BITS_KH2;
  localparam int N_SH  = 2 ** BITS_SH;

  logic [BITS_SH-1:0]    count;
  logic                  count_last;
  logic [BITS_SHIFT-1:0] lut_general [N_KH2][N_SH];
  logic [BITS_SHIFT-1:0] lut_last    [N_KH2][N_SH];

  // Shift tables for every kernel height and stride.
  for (genvar g_kh2 = 0; g_kh2 < N_KH2; g_kh2++) begin : g_kh2_row
    for (genvar g_sh_1 = 0; g_sh_1 < N_SH; g_sh_1++) begin : g_sh_col
      localparam int K        = 2 * g_kh2 + 1;
      localparam int S        = g_sh_1 + 1;
      localparam int CEIL_KS  = (K + S - 1) / S;
      localparam int FLOOR_KS = K / S;

      assign lut_general[g_kh2][g_sh_1] = BITS_SHIFT'(CEIL_KS - 1);
      // Stride wider than kernel has no legal shift, clamp at zero.
      assign lut_last[g_kh2][g_sh_1] = (FLOOR_KS > 0) ? BITS_SHIFT'(FLOOR_KS - 1) : '0;
    end
  end

  assign count_last = (count == i_sh_1);

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count <= '0;
    end else if (i_clear) begin
      count <= '0;  // New image restarts the stride phase.
    end else if (i_beat) begin
      count <= count_last ? '0 : count + 1'b1;
    end
  end

  assign o_shift = count_last ? lut_last[i_kh2][i_sh_1] : lut_general[i_kh2][i_sh_1];

endmodule

`default_nettype wire

/* design/pixel_repacker.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_repacker #(
  parameter int WORD_WIDTH = 8,
  parameter int S_WORDS    = 4,
  parameter int M_WORDS    = 8
) (
  input  wire                                      aclk,
  input  wire                                      i_arst_n,
  input  wire  [pixels_pkg::BITS_WORDS-1:0]        i_words,
  input  wire                                      i_s_valid,
  input  wire                                      i_s_last,
  input  wire  [S_WORDS-1:0][WORD_WIDTH-1:0]       i_s_data,
  input  wire  [S_WORDS-1:0]                       i_s_keep,
  input  wire                                      i_m_ready,
  output logic                                     o_s_ready,
  output logic                                     o_m_valid,
  output logic [M_WORDS-1:0][WORD_WIDTH-1:0]       o_m_data,
  output logic                                     o_m_last
);

  // Room for one short group plus a full input beat.
  localparam int BUF_WORDS = M_WORDS + S_WORDS - 1;
  localparam int FILL_W    = $clog2(BUF_WORDS + 1);

  logic [BUF_WORDS-1:0][WORD_WIDTH-1:0] word_buf;
  logic [BUF_WORDS-1:0][WORD_WIDTH-1:0] word_next;
  logic [FILL_W-1:0]                    fill;
  logic [FILL_W-1:0]                    fill_next;
  logic [FILL_W-1:0]                    words_w;
  logic                                 last_pend;
  logic                                 s_beat;
  logic                                 m_beat;

  // Word count never exceeds M_WORDS.
  assign words_w = FILL_W'(i_words);

  // Input and output never overlap: input stops once a group is ready.
  assign o_s_ready = (fill < words_w) && !last_pend;
  assign o_m_valid = (fill >= words_w) || (last_pend && (fill != '0));
  assign o_m_last  = last_pend && (fill <= words_w);

  assign s_beat = i_s_valid && o_s_ready;
  assign m_beat = o_m_valid && i_m_ready;

  // ========================================
  // Append kept words or pop one group
  // ========================================
  always_comb begin : append_pop
    int idx;
    int src;
    word_next = word_buf;
    fill_next = fill;
    idx       = int'(fill);
    src       = 0;
    if (s_beat) begin
      // Holes in the keep mask are squeezed out.
      for (int i = 0; i < S_WORDS; i++) begin
        if (i_s_keep[i] && (idx < BUF_WORDS)) begin
          word_next[idx] = i_s_data[i];
          idx            = idx + 1;
        end
      end
      fill_next = FILL_W'(idx);
    end else if (m_beat) begin
      for (int j = 0; j < BUF_WORDS; j++) begin
        src          = j + int'(words_w);
        word_next[j] = (src < BUF_WORDS) ? word_buf[src] : '0;
      end
      fill_next = (fill > words_w) ? fill - words_w : '0;
    end
  end

  always_ff @(posedge aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      fill      <= '0;
      last_pend <= 1'b0;
    end else begin
      fill <= fill_next;
      if (s_beat && i_s_last) begin
        last_pend <= 1'b1;  // Hold input off until drained.
      end else if (m_beat && o_m_last) begin
        last_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    word_buf <= word_next;
  end

  // Oldest words first, zero past the group size or the fill.
  always_comb begin
    for (int w = 0; w < M_WORDS; w++) begin
      if ((w < int'(words_w)) && (w < int'(fill))) begin
        o_m_data[w] = word_buf[w];
      end else begin
        o_m_data[w] = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/pixels_pkg.sv */
`default_nettype none

package pixels_pkg;

  // Controller states.
  typedef enum logic [1:0] {
    ST_SET   = 2'd0,  // Waiting for the configuration beat.
    ST_ONES  = 2'd1,  // Sending the ones beat.
    ST_PASS  = 2'd2,  // Streaming pixels through the repacker.
    ST_BLOCK = 2'd3   // Input closed, draining the repacker.
  } dw_state_e;

  // ========================================
  // Configuration beat layout
  // ========================================
  localparam int BITS_KH2   = 2;  // Kernel height is 2*kh2+1.
  localparam int BITS_SH    = 2;  // Stride minus one.
  localparam int BITS_WORDS = 4;  // Output words per beat.

  localparam int CFG_IS_NOT_MAX = 0;
  localparam int CFG_IS_MAX     = 1;
  localparam int CFG_IS_LRELU   = 2;
  localparam int CFG_KH2_LSB    = 3;
  localparam int CFG_SH_1_LSB   = CFG_KH2_LSB + BITS_KH2;
  localparam int CFG_WORDS_LSB  = CFG_SH_1_LSB + BITS_SH;
  localparam int CFG_WIDTH      = CFG_WORDS_LSB + BITS_WORDS;  // 11 bits.

  // Shift amount, up to ceil(7/1)-1.
  localparam int BITS_SHIFT = 3;

  // ========================================
  // User flags on the output beat
  // ========================================
  localparam int TUSER_WIDTH  = 3;
  localparam int I_IS_NOT_MAX = 0;
  localparam int I_IS_MAX     = 1;
  localparam int I_IS_LRELU   = 2;

endpackage

`default_nettype wire
